/* src.f */
logic/mipsPkg.sv
logic/aluDecoder.sv
logic/alu.sv
logic/regFile.sv
logic/controlUnit.sv
logic/datapath.sv
logic/mipsCore.sv
dv/clockGen.sv
dv/tbMipsCore.sv

/* Makefile */
RTL = logic/mipsPkg.sv logic/aluDecoder.sv logic/alu.sv logic/regFile.sv \
	logic/controlUnit.sv logic/datapath.sv logic/mipsCore.sv

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tbMipsCore -f src.f -o simTb

run: build
	@out=$$(./obj_dir/simTb); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only -Wall --top-module mipsCore $(RTL)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* dv/tbMipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore;

	// Load cycles plus run cycles of each test, in test order
	localparam int porCycles = 16;
	localparam int testCycles = porCycles + 86 + 89 + 35 + 65 + 17;
	// 20% headroom
	localparam int cycleLimit = testCycles + testCycles / 5;

	logic cclk;
	logic porRstb;
	logic testRstb;
	logic rstb;
	logic [mipsPkg::dataW-1:0] memAddr;
	logic [mipsPkg::dataW-1:0] memWdata;
	logic [mipsPkg::dataW-1:0] memRdata;
	logic memWe;

	// Image load port into the memory model
	logic loadEn;
	logic [7:0] loadAddr;
	logic [31:0] loadData;

	// 256-word unified memory
	logic [31:0] mem [256];

	// Observed stores and ALU operations of the current run
	logic [31:0] stAddr [16];
	logic [31:0] stData [16];
	logic [31:0] stCycle [16];
	int stCount;
	mipsPkg::aluCtrlT opLog [16];
	int opCount;
	int runCycle;
	int totalCycles = 0;

	// Program image and expected responses
	logic [31:0] prog [$];
	logic [7:0] dataIdx [$];
	logic [31:0] dataWord [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	int expCycle [$];
	mipsPkg::aluCtrlT expAlu [$];
	int runTotal;

	logic [31:0] lfsr;
	int errors;
	int checks;

	clockGen i_clockGen (
		.cclk(cclk),
		.rstb(porRstb)
	);

	// Core sees both power-on and per-test reset
	assign rstb = porRstb && testRstb;

	mipsCore i_mipsCore (
		.cclk(cclk),
		.rstb(rstb),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWe(memWe),
		.memRdata(memRdata)
	);

	// Same-cycle read
	assign memRdata = mem[memAddr[9:2]];

	// Memory write and bus observer, sampled before the edge's updates
	always @(posedge cclk) begin
		if (loadEn) begin
			mem[loadAddr] <= loadData;
		end else if (rstb && memWe) begin
			mem[memAddr[9:2]] <= memWdata;
		end
		if (!rstb) begin
			runCycle = 0;
			stCount = 0;
			opCount = 0;
		end else begin
			// Cycle 1 ends at the first edge after release
			runCycle = runCycle + 1;
			if (memWe && stCount < 16) begin
				stAddr[stCount] = memAddr;
				stData[stCount] = memWdata;
				stCycle[stCount] = runCycle;
				stCount = stCount + 1;
			end
			if ((i_mipsCore.i_controlUnit.state == mipsPkg::execute ||
				i_mipsCore.i_controlUnit.state == mipsPkg::itypeExecute) && opCount < 16) begin
				opLog[opCount] = i_mipsCore.aluControl;
				opCount = opCount + 1;
			end
		end
	end

	// Run length guard
	always @(posedge cclk) begin
		totalCycles <= totalCycles + 1;
		if (totalCycles > cycleLimit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	// Galois LFSR, taps 32 30 26 25
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// One step per bit taken
	function automatic logic [31:0] randWord();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsrNext(lfsr);
			w = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	// Instruction encoders
	function automatic logic [31:0] rInstr(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'd0, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jInstr(input logic [25:0] target);
		return {mipsPkg::j, target};
	endfunction

	// Cycle table, FETCH to next FETCH
	function automatic int cyclesOf(input logic [31:0] word);
		case (word[31:26])
			mipsPkg::lw: return 5;
			mipsPkg::beq, mipsPkg::bne, mipsPkg::j: return 3;
			default: return 4;
		endcase
	endfunction

	// Instructions that pass through an execute state
	function automatic bit hasAluState(input logic [31:0] word);
		return word[31:26] inside {mipsPkg::rType, mipsPkg::addi, mipsPkg::slti,
			mipsPkg::andi, mipsPkg::ori, mipsPkg::xori, mipsPkg::lui};
	endfunction

	// Expected ALU operation per instruction
	function automatic mipsPkg::aluCtrlT aluFor(input logic [31:0] word);
		case (word[31:26])
			mipsPkg::rType: begin
				case (word[5:0])
					mipsPkg::sub: return mipsPkg::aluSub;
					mipsPkg::andF: return mipsPkg::aluAnd;
					mipsPkg::orF: return mipsPkg::aluOr;
					mipsPkg::xorF: return mipsPkg::aluXor;
					mipsPkg::norF: return mipsPkg::aluNor;
					mipsPkg::slt: return mipsPkg::aluSlt;
					default: return mipsPkg::aluAdd;
				endcase
			end
			mipsPkg::slti: return mipsPkg::aluSlt;
			mipsPkg::andi: return mipsPkg::aluAnd;
			mipsPkg::ori: return mipsPkg::aluOr;
			mipsPkg::xori: return mipsPkg::aluXor;
			mipsPkg::lui: return mipsPkg::aluLui;
			default: return mipsPkg::aluAdd;
		endcase
	endfunction

	// Reference results
	function automatic logic [31:0] expectR(input mipsPkg::functT fn, input logic [31:0] a,
		input logic [31:0] b);
		case (fn)
			mipsPkg::add: return a + b;
			mipsPkg::sub: return a - b;
			mipsPkg::andF: return a & b;
			mipsPkg::orF: return a | b;
			mipsPkg::xorF: return a ^ b;
			mipsPkg::norF: return ~(a | b);
			mipsPkg::slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] expectI(input mipsPkg::opcodeT op, input logic [31:0] a,
		input logic [15:0] imm);
		logic [31:0] sext;
		logic [31:0] zext;
		sext = {{16{imm[15]}}, imm};
		zext = {16'h0000, imm};
		case (op)
			mipsPkg::addi: return a + sext;
			mipsPkg::slti: return ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			mipsPkg::andi: return a & zext;
			mipsPkg::ori: return a | zext;
			mipsPkg::xori: return a ^ zext;
			mipsPkg::lui: return {imm, 16'h0000};
			default: return 32'd0;
		endcase
	endfunction

	task automatic checkWord(input string name, input logic [mipsPkg::dataW-1:0] expected,
		input logic [mipsPkg::dataW-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkAlu(input string name, input mipsPkg::aluCtrlT expected,
		input mipsPkg::aluCtrlT actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %s, actual %s", name, expected.name(),
				actual.name());
		end
	endtask

	task automatic newProgram();
		prog.delete();
		dataIdx.delete();
		dataWord.delete();
		expAddr.delete();
		expData.delete();
		expCycle.delete();
		expAlu.delete();
		runTotal = 0;
	endtask

	task automatic addData(input logic [7:0] idx, input logic [31:0] word);
		dataIdx.push_back(idx);
		dataWord.push_back(word);
	endtask

	// Append one word, executed ones add to the expected timeline
	task automatic put(input logic [31:0] word, input bit executed);
		prog.push_back(word);
		if (executed) begin
			// memWrite is the 4th cycle of sw
			if (word[31:26] == mipsPkg::sw) begin
				expCycle.push_back(runTotal + 4);
			end
			if (hasAluState(word)) begin
				expAlu.push_back(aluFor(word));
			end
			runTotal += cyclesOf(word);
		end
	endtask

	task automatic emitStore(input logic [4:0] rt, input logic [15:0] addr,
		input logic [31:0] data);
		put(iInstr(mipsPkg::sw, 5'd0, rt, addr), 1'b1);
		expAddr.push_back({16'h0000, addr});
		expData.push_back(data);
	endtask

	// Store on a path that must not run
	task automatic skipStore(input logic [4:0] rt, input logic [15:0] addr);
		put(iInstr(mipsPkg::sw, 5'd0, rt, addr), 1'b0);
	endtask

	task automatic checkResults(input string name);
		int i;
		checkWord({name, " store count"}, expAddr.size(), stCount);
		for (i = 0; i < expAddr.size() && i < stCount; i++) begin
			checkWord($sformatf("%s store %0d address", name, i), expAddr[i], stAddr[i]);
			checkWord($sformatf("%s store %0d data", name, i), expData[i], stData[i]);
			checkWord($sformatf("%s store %0d cycle", name, i), expCycle[i], stCycle[i]);
		end
		checkWord({name, " ALU op count"}, expAlu.size(), opCount);
		for (i = 0; i < expAlu.size() && i < opCount; i++) begin
			checkAlu($sformatf("%s ALU op %0d", name, i), expAlu[i], opLog[i]);
		end
	endtask

	// Load under reset, release, run the computed length, check
	task automatic runProgram(input string name);
		int i;
		// Parks the core on a self loop at the end
		put(jInstr(26'(prog.size())), 1'b0);
		testRstb = 1'b0;
		loadEn = 1'b1;
		for (i = 0; i < prog.size(); i++) begin
			loadAddr = 8'(i);
			loadData = prog[i];
			@(negedge cclk);
		end
		for (i = 0; i < dataIdx.size(); i++) begin
			loadAddr = dataIdx[i];
			loadData = dataWord[i];
			@(negedge cclk);
		end
		loadEn = 1'b0;
		testRstb = 1'b1;
		repeat (runTotal) @(posedge cclk);
		@(negedge cclk);
		checkResults(name);
	endtask

	// Two random operands through every R-type funct
	task automatic rTypeTest();
		logic [31:0] a;
		logic [31:0] b;
		mipsPkg::functT fList [7];
		int k;
		fList = '{mipsPkg::add, mipsPkg::sub, mipsPkg::andF, mipsPkg::orF, mipsPkg::xorF,
			mipsPkg::norF, mipsPkg::slt};
		newProgram();
		a = randWord();
		b = randWord();
		addData(8'd64, a);
		addData(8'd65, b);
		put(iInstr(mipsPkg::lw, 5'd0, 5'd1, 16'h0100), 1'b1);
		put(iInstr(mipsPkg::lw, 5'd0, 5'd2, 16'h0104), 1'b1);
		for (k = 0; k < 7; k++) begin
			put(rInstr(5'd1, 5'd2, 5'd3, fList[k]), 1'b1);
			emitStore(5'd3, 16'h0180 + 16'(k * 4), expectR(fList[k], a, b));
		end
		runProgram("rtype");
	endtask

	// Sign extension for addi/slti, zero extension for the logic ops
	task automatic iTypeTest();
		logic [31:0] a;
		logic [31:0] srcVal;
		mipsPkg::opcodeT opList [8];
		logic [4:0] rsList [8];
		logic [15:0] immList [8];
		int k;
		opList = '{mipsPkg::addi, mipsPkg::addi, mipsPkg::slti, mipsPkg::slti,
			mipsPkg::andi, mipsPkg::ori, mipsPkg::xori, mipsPkg::lui};
		rsList = '{5'd1, 5'd0, 5'd1, 5'd0, 5'd1, 5'd1, 5'd1, 5'd0};
		// slti of $0 against 0xFFFF tells the two extensions apart
		immList = '{16'hFF85, 16'hFFF6, 16'hFFF0, 16'hFFFF, 16'hF0F0, 16'h8001, 16'hFFFF,
			16'hBEEF};
		newProgram();
		a = randWord();
		addData(8'd64, a);
		put(iInstr(mipsPkg::lw, 5'd0, 5'd1, 16'h0100), 1'b1);
		for (k = 0; k < 8; k++) begin
			srcVal = (rsList[k] == 5'd0) ? 32'd0 : a;
			put(iInstr(opList[k], rsList[k], 5'd3, immList[k]), 1'b1);
			emitStore(5'd3, 16'h0180 + 16'(k * 4), expectI(opList[k], srcVal, immList[k]));
		end
		runProgram("itype");
	endtask

	// Copy through memory, then $zero ignores a write
	task automatic roundTripTest();
		logic [31:0] w;
		newProgram();
		w = randWord();
		addData(8'd64, w);
		put(iInstr(mipsPkg::lw, 5'd0, 5'd4, 16'h0100), 1'b1);
		emitStore(5'd4, 16'h01C0, w);
		put(iInstr(mipsPkg::addi, 5'd0, 5'd0, 16'h1234), 1'b1);
		emitStore(5'd0, 16'h0184, 32'd0);
		// Read back the copy
		put(iInstr(mipsPkg::lw, 5'd0, 5'd5, 16'h01C0), 1'b1);
		emitStore(5'd5, 16'h0188, w);
		runProgram("roundtrip");
		checkWord("roundtrip copy in memory", w, mem[112]);
	endtask

	// Taken and fall-through for beq and bne, markers on both paths
	task automatic branchTest();
		newProgram();
		put(iInstr(mipsPkg::addi, 5'd0, 5'd1, 16'd5), 1'b1);
		put(iInstr(mipsPkg::addi, 5'd0, 5'd2, 16'd5), 1'b1);
		put(iInstr(mipsPkg::addi, 5'd0, 5'd3, 16'd7), 1'b1);
		// beq taken
		put(iInstr(mipsPkg::beq, 5'd1, 5'd2, 16'd1), 1'b1);
		skipStore(5'd0, 16'h01A0);
		emitStore(5'd1, 16'h01A4, 32'd5);
		// beq not taken
		put(iInstr(mipsPkg::beq, 5'd1, 5'd3, 16'd1), 1'b1);
		emitStore(5'd2, 16'h01A8, 32'd5);
		emitStore(5'd3, 16'h01AC, 32'd7);
		// bne taken
		put(iInstr(mipsPkg::bne, 5'd1, 5'd3, 16'd1), 1'b1);
		skipStore(5'd0, 16'h01B0);
		emitStore(5'd3, 16'h01B4, 32'd7);
		// bne not taken
		put(iInstr(mipsPkg::bne, 5'd1, 5'd2, 16'd1), 1'b1);
		emitStore(5'd1, 16'h01B8, 32'd5);
		emitStore(5'd2, 16'h01BC, 32'd5);
		runProgram("branch");
	endtask

	// j over a store, store timing from the cycle table
	task automatic jumpTimingTest();
		newProgram();
		emitStore(5'd0, 16'h0190, 32'd0);
		put(jInstr(26'd3), 1'b1);
		skipStore(5'd0, 16'h0194);
		emitStore(5'd0, 16'h0198, 32'd0);
		runProgram("jump");
		// First sw after reset writes in cycle 4
		checkWord("jump first store cycle", 32'd4, stCycle[0]);
	endtask

	initial begin
		testRstb = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		lfsr = 32'd95;
		errors = 0;
		checks = 0;
		runTotal = 0;
		wait (porRstb);
		@(negedge cclk);
		rTypeTest();
		iTypeTest();
		roundTripTest();
		branchTest();
		jumpTimingTest();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic cclk,
	output logic rstb
);

	// 40 ns period
	initial begin
		cclk = 1'b0;
		forever #20 cclk = ~cclk;
	end

	// Power-on reset, 16 rising edges, released on a falling edge
	initial begin
		rstb = 1'b0;
		repeat (16) @(posedge cclk);
		@(negedge cclk);
		rstb = 1'b1;
	end

endmodule

`default_nettype wire

/* logic/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input logic cclk,
	input logic rstb,
	output logic [mipsPkg::dataW-1:0] memAddr,
	output logic [mipsPkg::dataW-1:0] memWdata,
	output logic memWe,
	input logic [mipsPkg::dataW-1:0] memRdata
);

	// Control to datapath
	logic memtoReg;
	logic iOrD;
	logic regDst;
	logic [1:0] pcSrc;
	logic aluSrcA;
	logic [1:0] aluSrcB;
	logic irWrite;
	logic pcWrite;
	logic regWrite;
	logic [1:0] branch;
	logic extOp;
	mipsPkg::aluCtrlT aluControl;
	// Instruction fields back to control
	mipsPkg::opcodeT opcode;
	mipsPkg::functT funct;

	controlUnit i_controlUnit (
		.cclk(cclk),
		.rstb(rstb),
		.opcode(opcode),
		.funct(funct),
		.memtoReg(memtoReg),
		.iOrD(iOrD),
		.regDst(regDst),
		.pcSrc(pcSrc),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.irWrite(irWrite),
		.memWrite(memWe),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.branch(branch),
		.extOp(extOp),
		.aluControl(aluControl)
	);

	datapath i_datapath (
		.cclk(cclk),
		.rstb(rstb),
		.memtoReg(memtoReg),
		.iOrD(iOrD),
		.regDst(regDst),
		.pcSrc(pcSrc),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.irWrite(irWrite),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.branch(branch),
		.extOp(extOp),
		.aluControl(aluControl),
		.memRdata(memRdata),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.opcode(opcode),
		.funct(funct)
	);

endmodule

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input logic cclk,
	input logic rstb,
	input logic memtoReg,
	input logic iOrD,
	input logic regDst,
	input logic [1:0] pcSrc,
	input logic aluSrcA,
	input logic [1:0] aluSrcB,
	input logic irWrite,
	input logic pcWrite,
	input logic regWrite,
	input logic [1:0] branch,
	input logic extOp,
	input mipsPkg::aluCtrlT aluControl,
	input logic [mipsPkg::dataW-1:0] memRdata,
	output logic [mipsPkg::dataW-1:0] memAddr,
	output logic [mipsPkg::dataW-1:0] memWdata,
	output mipsPkg::opcodeT opcode,
	output mipsPkg::functT funct
);

	// Architectural and temporary registers
	logic [mipsPkg::dataW-1:0] pc;
	logic [mipsPkg::dataW-1:0] ir;
	logic [mipsPkg::dataW-1:0] mdr;
	logic [mipsPkg::dataW-1:0] regA;
	logic [mipsPkg::dataW-1:0] regB;
	logic [mipsPkg::dataW-1:0] aluOut;

	logic [mipsPkg::dataW-1:0] rd1;
	logic [mipsPkg::dataW-1:0] rd2;
	logic [mipsPkg::dataW-1:0] immExt;
	logic [mipsPkg::dataW-1:0] srcA;
	logic [mipsPkg::dataW-1:0] srcB;
	logic [mipsPkg::dataW-1:0] aluResult;
	logic [mipsPkg::dataW-1:0] pcNext;
	logic [mipsPkg::regAddrW-1:0] wa;
	logic [mipsPkg::dataW-1:0] wd;
	logic zero;
	logic pcEn;

	// Fields back to the FSM
	assign opcode = mipsPkg::opcodeT'(ir[31:26]);
	assign funct = mipsPkg::functT'(ir[5:0]);

	// Unified memory port
	assign memAddr = iOrD ? aluOut : pc;
	assign memWdata = regB;

	// Sign or zero extension of the 16-bit immediate
	assign immExt = extOp ? {{(mipsPkg::dataW-16){ir[15]}}, ir[15:0]}
		: {{(mipsPkg::dataW-16){1'b0}}, ir[15:0]};

	// rd for R-type, rt otherwise
	assign wa = (regDst == mipsPkg::regDstRd) ? ir[15:11] : ir[20:16];
	assign wd = memtoReg ? mdr : aluOut;

	regFile i_regFile (
		.cclk(cclk),
		.ra1(ir[25:21]),
		.ra2(ir[20:16]),
		.wa(wa),
		.we(regWrite),
		.wd(wd),
		.rd1(rd1),
		.rd2(rd2)
	);

	assign srcA = aluSrcA ? regA : pc;

	always_comb begin
		case (aluSrcB)
			mipsPkg::srcBReg: srcB = regB;
			mipsPkg::srcBFour: srcB = 32'd4;
			mipsPkg::srcBImm: srcB = immExt;
			mipsPkg::srcBImmShift: srcB = immExt << 2;
			default: srcB = regB;
		endcase
	end

	alu i_alu (
		.a(srcA),
		.b(srcB),
		.aluControl(aluControl),
		.result(aluResult),
		.zero(zero)
	);

	always_comb begin
		case (pcSrc)
			mipsPkg::pcSrcAlu: pcNext = aluResult;
			mipsPkg::pcSrcAluOut: pcNext = aluOut;
			// pc already holds PC+4 here
			mipsPkg::pcSrcJump: pcNext = {pc[31:28], ir[25:0], 2'b00};
			default: pcNext = aluResult;
		endcase
	end

	// beq on zero, bne on not zero
	assign pcEn = pcWrite || (branch[0] && zero) || (branch[1] && !zero);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= '0;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	// IR holds across the instruction
	always_ff @(posedge cclk) begin
		if (irWrite) begin
			ir <= memRdata;
		end
	end

	// Temporaries load every cycle
	always_ff @(posedge cclk) begin
		mdr <= memRdata;
		regA <= rd1;
		regB <= rd2;
		aluOut <= aluResult;
	end

	// Fetch addresses stay word-aligned
	aPcAligned: assert property (@(posedge cclk) disable iff (!rstb) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic cclk,
	input logic rstb,
	input mipsPkg::opcodeT opcode,
	input mipsPkg::functT funct,
	// Mux selects
	output logic memtoReg,
	output logic iOrD,
	output logic regDst,
	output logic [1:0] pcSrc,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	// Write enables
	output logic irWrite,
	output logic memWrite,
	output logic pcWrite,
	output logic regWrite,
	// Bit 1 bne, bit 0 beq
	output logic [1:0] branch,
	output logic extOp,
	output mipsPkg::aluCtrlT aluControl
);

	mipsPkg::stateT state;
	mipsPkg::stateT nextState;
	mipsPkg::aluOpT aluOp;

	aluDecoder i_aluDecoder (
		.funct(funct),
		.aluOp(aluOp),
		.opcode(opcode),
		.aluControl(aluControl)
	);

	// Zero extension only for the logical immediates
	assign extOp = !(opcode inside {mipsPkg::andi, mipsPkg::ori, mipsPkg::xori});

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= mipsPkg::fetch;
		end else begin
			state <= nextState;
		end
	end

	// Next state
	always_comb begin
		nextState = mipsPkg::fetch;
		case (state)
			mipsPkg::fetch: nextState = mipsPkg::decode;
			mipsPkg::decode: begin
				case (opcode)
					mipsPkg::lw, mipsPkg::sw: nextState = mipsPkg::memAdr;
					mipsPkg::rType: nextState = mipsPkg::execute;
					mipsPkg::beq, mipsPkg::bne: nextState = mipsPkg::branch;
					mipsPkg::addi, mipsPkg::slti, mipsPkg::andi,
					mipsPkg::ori, mipsPkg::xori, mipsPkg::lui: begin
						nextState = mipsPkg::itypeExecute;
					end
					mipsPkg::j: nextState = mipsPkg::jump;
					// Unknown opcode, skip it
					default: nextState = mipsPkg::fetch;
				endcase
			end
			mipsPkg::memAdr: begin
				if (opcode == mipsPkg::lw) begin
					nextState = mipsPkg::memRead;
				end else begin
					nextState = mipsPkg::memWrite;
				end
			end
			mipsPkg::memRead: nextState = mipsPkg::memWriteback;
			mipsPkg::execute: nextState = mipsPkg::aluWriteback;
			mipsPkg::itypeExecute: nextState = mipsPkg::itypeWriteback;
			// Writebacks, memWrite, branch and jump all end the instruction
			default: nextState = mipsPkg::fetch;
		endcase
	end

	// Outputs from state only, everything inactive unless set
	always_comb begin
		memtoReg = 1'b0;
		iOrD = 1'b0;
		regDst = mipsPkg::regDstRt;
		pcSrc = mipsPkg::pcSrcAlu;
		aluSrcA = 1'b0;
		aluSrcB = mipsPkg::srcBReg;
		irWrite = 1'b0;
		memWrite = 1'b0;
		pcWrite = 1'b0;
		regWrite = 1'b0;
		branch = 2'b00;
		aluOp = mipsPkg::opAdd;
		case (state)
			// IR load and PC+4 in the same cycle
			mipsPkg::fetch: begin
				aluSrcB = mipsPkg::srcBFour;
				irWrite = 1'b1;
				pcWrite = 1'b1;
			end
			// Branch target into aluOut
			mipsPkg::decode: aluSrcB = mipsPkg::srcBImmShift;
			mipsPkg::memAdr: begin
				aluSrcA = 1'b1;
				aluSrcB = mipsPkg::srcBImm;
			end
			mipsPkg::memRead: iOrD = 1'b1;
			mipsPkg::memWriteback: begin
				memtoReg = 1'b1;
				regWrite = 1'b1;
			end
			mipsPkg::memWrite: begin
				iOrD = 1'b1;
				memWrite = 1'b1;
			end
			mipsPkg::execute: begin
				aluSrcA = 1'b1;
				aluOp = mipsPkg::opFunct;
			end
			mipsPkg::aluWriteback: begin
				regDst = mipsPkg::regDstRd;
				regWrite = 1'b1;
			end
			// Compare regA and regB, target from aluOut
			mipsPkg::branch: begin
				aluSrcA = 1'b1;
				pcSrc = mipsPkg::pcSrcAluOut;
				aluOp = mipsPkg::opSub;
				branch = (opcode == mipsPkg::bne) ? 2'b10 : 2'b01;
			end
			mipsPkg::itypeExecute: begin
				aluSrcA = 1'b1;
				aluSrcB = mipsPkg::srcBImm;
				aluOp = mipsPkg::opImm;
			end
			mipsPkg::itypeWriteback: regWrite = 1'b1;
			mipsPkg::jump: begin
				pcSrc = mipsPkg::pcSrcJump;
				pcWrite = 1'b1;
			end
			default: ;
		endcase
	end

	// Store and register write belong to different instructions' final states
	aMemRegExcl: assert property (@(posedge cclk) disable iff (!rstb)
		!(memWrite && regWrite));

	// State register never leaves the encoded set
	aLegalState: assert property (@(posedge cclk) disable iff (!rstb)
		state inside {mipsPkg::fetch, mipsPkg::decode, mipsPkg::memAdr, mipsPkg::memRead,
			mipsPkg::memWriteback, mipsPkg::memWrite, mipsPkg::execute,
			mipsPkg::aluWriteback, mipsPkg::branch, mipsPkg::itypeExecute,
			mipsPkg::itypeWriteback, mipsPkg::jump});

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input logic cclk,
	input logic [mipsPkg::regAddrW-1:0] ra1,
	input logic [mipsPkg::regAddrW-1:0] ra2,
	input logic [mipsPkg::regAddrW-1:0] wa,
	input logic we,
	input logic [mipsPkg::dataW-1:0] wd,
	output logic [mipsPkg::dataW-1:0] rd1,
	output logic [mipsPkg::dataW-1:0] rd2
);

	logic [mipsPkg::dataW-1:0] regs [2**mipsPkg::regAddrW];

	// Single write port, $zero never written
	always_ff @(posedge cclk) begin
		if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// Combinational reads, $zero forced
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input logic [mipsPkg::dataW-1:0] a,
	input logic [mipsPkg::dataW-1:0] b,
	input mipsPkg::aluCtrlT aluControl,
	output logic [mipsPkg::dataW-1:0] result,
	output logic zero
);

	always_comb begin
		case (aluControl)
			mipsPkg::aluAnd: result = a & b;
			mipsPkg::aluOr: result = a | b;
			mipsPkg::aluAdd: result = a + b;
			mipsPkg::aluXor: result = a ^ b;
			mipsPkg::aluNor: result = ~(a | b);
			mipsPkg::aluSub: result = a - b;
			// Signed less-than, result 0 or 1
			mipsPkg::aluSlt: begin
				result = '0;
				result[0] = $signed(a) < $signed(b);
			end
			// Immediate into the upper half
			mipsPkg::aluLui: result = b << 16;
			default: result = '0;
		endcase
	end

	// Branch compare flag
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* logic/aluDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
	input mipsPkg::functT funct,
	input mipsPkg::aluOpT aluOp,
	input mipsPkg::opcodeT opcode,
	output mipsPkg::aluCtrlT aluControl
);

	always_comb begin
		// Address and PC arithmetic by default
		aluControl = mipsPkg::aluAdd;
		case (aluOp)
			mipsPkg::opAdd: aluControl = mipsPkg::aluAdd;
			// Branch compare
			mipsPkg::opSub: aluControl = mipsPkg::aluSub;
			// R-type, operation from funct
			mipsPkg::opFunct: begin
				case (funct)
					mipsPkg::add: aluControl = mipsPkg::aluAdd;
					mipsPkg::sub: aluControl = mipsPkg::aluSub;
					mipsPkg::andF: aluControl = mipsPkg::aluAnd;
					mipsPkg::orF: aluControl = mipsPkg::aluOr;
					mipsPkg::xorF: aluControl = mipsPkg::aluXor;
					mipsPkg::norF: aluControl = mipsPkg::aluNor;
					mipsPkg::slt: aluControl = mipsPkg::aluSlt;
					default: aluControl = mipsPkg::aluAdd;
				endcase
			end
			// I-type, operation from opcode
			mipsPkg::opImm: begin
				case (opcode)
					mipsPkg::slti: aluControl = mipsPkg::aluSlt;
					mipsPkg::andi: aluControl = mipsPkg::aluAnd;
					mipsPkg::ori: aluControl = mipsPkg::aluOr;
					mipsPkg::xori: aluControl = mipsPkg::aluXor;
					mipsPkg::lui: aluControl = mipsPkg::aluLui;
					// addi
					default: aluControl = mipsPkg::aluAdd;
				endcase
			end
			default: aluControl = mipsPkg::aluAdd;
		endcase
	end

endmodule

`default_nettype wire

/* logic/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	// Datapath widths
	localparam int dataW = 32;
	localparam int regAddrW = 5;

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		rType = 6'd0,
		j = 6'd2,
		beq = 6'd4,
		bne = 6'd5,
		addi = 6'd8,
		slti = 6'd10,
		andi = 6'd12,
		ori = 6'd13,
		xori = 6'd14,
		lui = 6'd15,
		lw = 6'd35,
		sw = 6'd43
	} opcodeT;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		add = 6'd32,
		sub = 6'd34,
		andF = 6'd36,
		orF = 6'd37,
		xorF = 6'd38,
		norF = 6'd39,
		slt = 6'd42
	} functT;

	// Multicycle FSM states
	typedef enum logic [3:0] {
		fetch,
		decode,
		memAdr,
		memRead,
		memWriteback,
		memWrite,
		execute,
		aluWriteback,
		branch,
		itypeExecute,
		itypeWriteback,
		jump
	} stateT;

	// ALU operation codes
	typedef enum logic [3:0] {
		aluAnd = 4'd0,
		aluOr = 4'd1,
		aluAdd = 4'd2,
		aluXor = 4'd3,
		aluNor = 4'd4,
		aluSub = 4'd6,
		aluSlt = 4'd7,
		aluLui = 4'd8
	} aluCtrlT;

	// Coarse ALU request from the FSM to the ALU decoder
	typedef enum logic [1:0] {
		opAdd,
		opSub,
		opFunct,
		opImm
	} aluOpT;

	// ALU B operand select
	localparam logic [1:0] srcBReg = 2'd0;
	localparam logic [1:0] srcBFour = 2'd1;
	localparam logic [1:0] srcBImm = 2'd2;
	localparam logic [1:0] srcBImmShift = 2'd3;

	// Next PC select
	localparam logic [1:0] pcSrcAlu = 2'd0;
	localparam logic [1:0] pcSrcAluOut = 2'd1;
	localparam logic [1:0] pcSrcJump = 2'd2;

	// Destination register select
	localparam logic regDstRt = 1'b0;
	localparam logic regDstRd = 1'b1;

endpackage

`default_nettype wire
